// ==== common/rv_pkg.sv ====
// ******************************************************************
// widths, register count, funct7 codes, opcode and alu operation enums
// ******************************************************************
`default_nettype none

package rv_pkg;

    // data path width
    localparam int xlen = 32;

    // register index width and number of architectural registers
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;

    // funct7 field values
    // alt selects sub and arithmetic right shift
    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } opcode_e;

    // alu operations
    // pass_b forwards operand b untouched, used for lui
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

endpackage

`default_nettype wire

// ==== design/regfile.sv ====
// ******************************************************************
// three port register file, two async reads and one clocked write
// ******************************************************************
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  logic                          clk,
    // write port
    input  logic                          we3,
    input  logic [rv_pkg::reg_addr_w-1:0] a3,
    input  logic [rv_pkg::xlen-1:0]       wd3,
    // read ports
    input  logic [rv_pkg::reg_addr_w-1:0] a1,
    input  logic [rv_pkg::reg_addr_w-1:0] a2,
    output logic [rv_pkg::xlen-1:0]       rd1,
    output logic [rv_pkg::xlen-1:0]       rd2
);

    // register storage, contents undefined until written
    logic [rv_pkg::xlen-1:0] rf [rv_pkg::reg_count];

    // write on rising edge
    // x0 gets written too, the read side hides it
    always_ff @(posedge clk)
    begin
        if (we3)
        begin
            rf[a3] <= wd3;
        end
    end

    // combinational reads
    // index 0 always reads as zero
    assign rd1 = (a1 != '0) ? rf[a1] : '0;
    assign rd2 = (a2 != '0) ? rf[a2] : '0;

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
// ******************************************************************
// instruction decode, operand read with forwarding, decode register
// ******************************************************************
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           instr_valid,
    input  logic [31:0]                    instr,
    // register file read
    output logic [rv_pkg::reg_addr_w-1:0]  a1,
    output logic [rv_pkg::reg_addr_w-1:0]  a2,
    input  logic [rv_pkg::xlen-1:0]        rd1,
    input  logic [rv_pkg::xlen-1:0]        rd2,
    // forwarding sources
    input  logic [rv_pkg::xlen-1:0]        alu_result,
    input  logic                           e_valid,
    input  logic                           e_illegal,
    input  logic [rv_pkg::reg_addr_w-1:0]  e_rd,
    input  logic [rv_pkg::xlen-1:0]        e_result,
    input  logic                           w_valid,
    input  logic                           w_illegal,
    input  logic [rv_pkg::reg_addr_w-1:0]  w_rd,
    input  logic [rv_pkg::xlen-1:0]        w_data,
    // decoded bundle to execute
    output logic                           d_valid,
    output logic                           d_illegal,
    output logic [rv_pkg::reg_addr_w-1:0]  d_rd,
    output rv_pkg::alu_op_e                d_alu_op,
    output logic [rv_pkg::xlen-1:0]        d_op_a,
    output logic [rv_pkg::xlen-1:0]        d_op_b
);

    rv_pkg::opcode_e         opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [rv_pkg::xlen-1:0] imm_i;
    logic [rv_pkg::xlen-1:0] imm_u;
    rv_pkg::alu_op_e         alu_op;
    logic                    illegal;
    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;

    // youngest in-flight writer wins, x0 never forwards
    function automatic logic [rv_pkg::xlen-1:0] fwd_select(
        input logic [rv_pkg::reg_addr_w-1:0] idx,
        input logic [rv_pkg::xlen-1:0]       rf_val
    );
        logic [rv_pkg::xlen-1:0] val;
        val = rf_val;
        if (idx != '0)
        begin
            if (d_valid && !d_illegal && d_rd == idx)
                val = alu_result;
            else if (e_valid && !e_illegal && e_rd == idx)
                val = e_result;
            // written at the same edge that captures the operand
            else if (w_valid && !w_illegal && w_rd == idx)
                val = w_data;
        end
        return val;
    endfunction

    // instruction fields
    assign opcode = rv_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign a1     = instr[19:15];
    assign a2     = instr[24:20];

    // sign extended i-type and upper u-type immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    // opcode / funct to alu operation
    always_comb
    begin
        alu_op  = rv_pkg::alu_add;
        illegal = 1'b0;
        case (opcode)
            rv_pkg::op_reg:
            begin
                if (funct7 == rv_pkg::funct7_base)
                begin
                    case (funct3)
                        3'b000: alu_op = rv_pkg::alu_add;
                        3'b001: alu_op = rv_pkg::alu_sll;
                        3'b010: alu_op = rv_pkg::alu_slt;
                        3'b011: alu_op = rv_pkg::alu_sltu;
                        3'b100: alu_op = rv_pkg::alu_xor;
                        3'b101: alu_op = rv_pkg::alu_srl;
                        3'b110: alu_op = rv_pkg::alu_or;
                        default: alu_op = rv_pkg::alu_and;
                    endcase
                end
                else if (funct7 == rv_pkg::funct7_alt && funct3 == 3'b000)
                    alu_op = rv_pkg::alu_sub;
                else if (funct7 == rv_pkg::funct7_alt && funct3 == 3'b101)
                    alu_op = rv_pkg::alu_sra;
                else
                    illegal = 1'b1;
            end
            rv_pkg::op_imm:
            begin
                case (funct3)
                    3'b000: alu_op = rv_pkg::alu_add;
                    3'b010: alu_op = rv_pkg::alu_slt;
                    3'b011: alu_op = rv_pkg::alu_sltu;
                    3'b100: alu_op = rv_pkg::alu_xor;
                    3'b110: alu_op = rv_pkg::alu_or;
                    3'b111: alu_op = rv_pkg::alu_and;
                    // shift immediates still constrain funct7
                    3'b001:
                    begin
                        alu_op  = rv_pkg::alu_sll;
                        illegal = (funct7 != rv_pkg::funct7_base);
                    end
                    default:
                    begin
                        if (funct7 == rv_pkg::funct7_base)
                            alu_op = rv_pkg::alu_srl;
                        else if (funct7 == rv_pkg::funct7_alt)
                            alu_op = rv_pkg::alu_sra;
                        else
                            illegal = 1'b1;
                    end
                endcase
            end
            rv_pkg::op_lui:
                alu_op = rv_pkg::alu_pass_b;
            default:
                illegal = 1'b1;
        endcase
    end

    // operand select
    // op_b is imm for op_imm and lui, forwarded rs2 otherwise
    always_comb
    begin
        op_a = fwd_select(a1, rd1);
        case (opcode)
            rv_pkg::op_imm: op_b = imm_i;
            rv_pkg::op_lui: op_b = imm_u;
            default:        op_b = fwd_select(a2, rd2);
        endcase
    end

    // decode register, control bits
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            d_valid   <= 1'b0;
            d_illegal <= 1'b0;
        end
        else
        begin
            d_valid   <= instr_valid;
            d_illegal <= illegal;
        end
    end

    // decode register, payload
    always_ff @(posedge clk)
    begin
        d_rd     <= instr[11:7];
        d_alu_op <= alu_op;
        d_op_a   <= op_a;
        d_op_b   <= op_b;
    end

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
// ******************************************************************
// rv32i integer alu and execute pipeline register
// ******************************************************************
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    // decoded bundle
    input  logic                          d_valid,
    input  logic                          d_illegal,
    input  logic [rv_pkg::reg_addr_w-1:0] d_rd,
    input  rv_pkg::alu_op_e               d_alu_op,
    input  logic [rv_pkg::xlen-1:0]       d_op_a,
    input  logic [rv_pkg::xlen-1:0]       d_op_b,
    // unregistered result, forwarded back to decode
    output logic [rv_pkg::xlen-1:0]       alu_result,
    // execute register
    output logic                          e_valid,
    output logic                          e_illegal,
    output logic [rv_pkg::reg_addr_w-1:0] e_rd,
    output logic [rv_pkg::xlen-1:0]       e_result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // only the low five bits shift
    assign shamt = d_op_b[4:0];

    // compares for slt / sltu
    assign lt_signed   = $signed(d_op_a) < $signed(d_op_b);
    assign lt_unsigned = d_op_a < d_op_b;

    always_comb
    begin
        case (d_alu_op)
            rv_pkg::alu_add:    alu_result = d_op_a + d_op_b;
            rv_pkg::alu_sub:    alu_result = d_op_a - d_op_b;
            rv_pkg::alu_sll:    alu_result = d_op_a << shamt;
            rv_pkg::alu_slt:    alu_result = {{(rv_pkg::xlen-1){1'b0}}, lt_signed};
            rv_pkg::alu_sltu:   alu_result = {{(rv_pkg::xlen-1){1'b0}}, lt_unsigned};
            rv_pkg::alu_xor:    alu_result = d_op_a ^ d_op_b;
            rv_pkg::alu_srl:    alu_result = d_op_a >> shamt;
            // arithmetic shift keeps the sign bit
            rv_pkg::alu_sra:    alu_result = $unsigned($signed(d_op_a) >>> shamt);
            rv_pkg::alu_or:     alu_result = d_op_a | d_op_b;
            rv_pkg::alu_and:    alu_result = d_op_a & d_op_b;
            rv_pkg::alu_pass_b: alu_result = d_op_b;
            // unused encodings
            default:            alu_result = '0;
        endcase
    end

    // valid and illegal tags
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            e_valid   <= 1'b0;
            e_illegal <= 1'b0;
        end
        else
        begin
            e_valid   <= d_valid;
            e_illegal <= d_illegal;
        end
    end

    // destination and result
    always_ff @(posedge clk)
    begin
        e_rd     <= d_rd;
        e_result <= alu_result;
    end

endmodule

`default_nettype wire

// ==== design/writeback_stage.sv ====
// ******************************************************************
// writeback register, register file write and retire record
// ******************************************************************
`timescale 1ns/1ns
`default_nettype none

module writeback_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    // from execute
    input  logic                          e_valid,
    input  logic                          e_illegal,
    input  logic [rv_pkg::reg_addr_w-1:0] e_rd,
    input  logic [rv_pkg::xlen-1:0]       e_result,
    // register file write port
    output logic                          we3,
    output logic [rv_pkg::reg_addr_w-1:0] a3,
    output logic [rv_pkg::xlen-1:0]       wd3,
    // retire record, also the forwarding source for decode
    output logic                          retire_valid,
    output logic                          retire_illegal,
    output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
    output logic [rv_pkg::xlen-1:0]       retire_data
);

    // tags
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            retire_valid   <= 1'b0;
            retire_illegal <= 1'b0;
        end
        else
        begin
            retire_valid   <= e_valid;
            retire_illegal <= e_illegal;
        end
    end

    // payload
    always_ff @(posedge clk)
    begin
        retire_rd   <= e_rd;
        retire_data <= e_result;
    end

    // illegal ops retire but never write
    assign we3 = retire_valid && !retire_illegal;
    assign a3  = retire_rd;
    assign wd3 = retire_data;

endmodule

`default_nettype wire

// ==== design/rv_alu_core.sv ====
// ******************************************************************
// rv32i alu pipeline top, decode / execute / writeback and regfile
// ******************************************************************
`timescale 1ns/1ns
`default_nettype none

module rv_alu_core (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          instr_valid,
    input  logic [31:0]                   instr,
    output logic                          retire_valid,
    output logic                          retire_illegal,
    output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
    output logic [rv_pkg::xlen-1:0]       retire_data
);

    // register file ports
    logic                          we3;
    logic [rv_pkg::reg_addr_w-1:0] a1;
    logic [rv_pkg::reg_addr_w-1:0] a2;
    logic [rv_pkg::reg_addr_w-1:0] a3;
    logic [rv_pkg::xlen-1:0]       rd1;
    logic [rv_pkg::xlen-1:0]       rd2;
    logic [rv_pkg::xlen-1:0]       wd3;

    // decode to execute
    logic                          d_valid;
    logic                          d_illegal;
    logic [rv_pkg::reg_addr_w-1:0] d_rd;
    rv_pkg::alu_op_e               d_alu_op;
    logic [rv_pkg::xlen-1:0]       d_op_a;
    logic [rv_pkg::xlen-1:0]       d_op_b;

    // execute to writeback, plus comb result for forwarding
    logic [rv_pkg::xlen-1:0]       alu_result;
    logic                          e_valid;
    logic                          e_illegal;
    logic [rv_pkg::reg_addr_w-1:0] e_rd;
    logic [rv_pkg::xlen-1:0]       e_result;

    regfile regfile_inst (
        .clk (clk),
        .we3 (we3),
        .a3  (a3),
        .wd3 (wd3),
        .a1  (a1),
        .a2  (a2),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    // writeback register doubles as the oldest forwarding source
    decode_stage decode_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .a1          (a1),
        .a2          (a2),
        .rd1         (rd1),
        .rd2         (rd2),
        .alu_result  (alu_result),
        .e_valid     (e_valid),
        .e_illegal   (e_illegal),
        .e_rd        (e_rd),
        .e_result    (e_result),
        .w_valid     (retire_valid),
        .w_illegal   (retire_illegal),
        .w_rd        (retire_rd),
        .w_data      (retire_data),
        .d_valid     (d_valid),
        .d_illegal   (d_illegal),
        .d_rd        (d_rd),
        .d_alu_op    (d_alu_op),
        .d_op_a      (d_op_a),
        .d_op_b      (d_op_b)
    );

    execute_stage execute_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .d_valid    (d_valid),
        .d_illegal  (d_illegal),
        .d_rd       (d_rd),
        .d_alu_op   (d_alu_op),
        .d_op_a     (d_op_a),
        .d_op_b     (d_op_b),
        .alu_result (alu_result),
        .e_valid    (e_valid),
        .e_illegal  (e_illegal),
        .e_rd       (e_rd),
        .e_result   (e_result)
    );

    writeback_stage writeback_stage_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .e_valid        (e_valid),
        .e_illegal      (e_illegal),
        .e_rd           (e_rd),
        .e_result       (e_result),
        .we3            (we3),
        .a3             (a3),
        .wd3            (wd3),
        .retire_valid   (retire_valid),
        .retire_illegal (retire_illegal),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data)
    );

endmodule

`default_nettype wire

// ==== bench/rv_alu_core_checker.sv ====
// ******************************************************************
// bound assertions on reset state, x0 reads and retire flags
// ******************************************************************
`timescale 1ns/1ns
`default_nettype none

module rv_alu_core_checker (
    input logic                          clk,
    input logic                          rst_n,
    // register file read ports
    input logic [rv_pkg::reg_addr_w-1:0] a1,
    input logic [rv_pkg::reg_addr_w-1:0] a2,
    input logic [rv_pkg::xlen-1:0]       rd1,
    input logic [rv_pkg::xlen-1:0]       rd2,
    // write enable, execute tags and retire tags
    input logic                          we3,
    input logic                          e_valid,
    input logic                          e_illegal,
    input logic                          retire_valid,
    input logic                          retire_illegal
);

    // failed assertion count, read by the testbench
    int fail_count = 0;

    // synchronous reset clears retire_valid one edge later
    retire_low_in_reset: assert property (@(posedge clk) !rst_n |=> !retire_valid)
    else
    begin
        fail_count++;
        $error("retire_valid high during reset");
    end

    // x0 reads as zero on both ports
    x0_read_port1: assert property (@(posedge clk) (a1 == '0) |-> (rd1 == '0))
    else
    begin
        fail_count++;
        $error("rd1 not zero for x0");
    end

    x0_read_port2: assert property (@(posedge clk) (a2 == '0) |-> (rd2 == '0))
    else
    begin
        fail_count++;
        $error("rd2 not zero for x0");
    end

    // an illegal op leaving execute retires flagged and never writes
    no_write_on_illegal: assert property (@(posedge clk)
        rst_n && e_valid && e_illegal |=> retire_illegal && !we3)
    else
    begin
        fail_count++;
        $error("register write on an illegal retire");
    end

endmodule

// a1, a2, rd1, rd2 are the regfile read nets inside the top
bind rv_alu_core rv_alu_core_checker rv_alu_core_checker_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .a1             (a1),
    .a2             (a2),
    .rd1            (rd1),
    .rd2            (rd2),
    .we3            (we3),
    .e_valid        (e_valid),
    .e_illegal      (e_illegal),
    .retire_valid   (retire_valid),
    .retire_illegal (retire_illegal)
);

`default_nettype wire

// ==== bench/rv_alu_core_tb.sv ====
// ******************************************************************
// testbench for rv_alu_core, cases from file, random idle gaps,
// in-order retire check against a queue of expected records
// ******************************************************************
`timescale 1ns/1ns
`default_nettype none

module rv_alu_core_tb;

    localparam int          clk_period   = 10;
    localparam int          reset_cycles = 8;
    localparam logic [31:0] seed         = 32'he4b3;
    localparam string       cases_file   = "bench/alu_cases.txt";
    localparam int          max_cases    = 128;
    // expected record is {illegal, rd, data}
    localparam int          rec_w        = 1 + rv_pkg::reg_addr_w + rv_pkg::xlen;

    logic                          clk;
    logic                          rst_n;
    logic                          instr_valid;
    logic [31:0]                   instr;
    logic                          retire_valid;
    logic                          retire_illegal;
    logic [rv_pkg::reg_addr_w-1:0] retire_rd;
    logic [rv_pkg::xlen-1:0]       retire_data;

    // cases as loaded from the file
    logic [31:0]                   case_instr   [max_cases];
    logic [rv_pkg::reg_addr_w-1:0] case_rd      [max_cases];
    logic [rv_pkg::xlen-1:0]       case_data    [max_cases];
    logic                          case_illegal [max_cases];
    logic                          case_burst   [max_cases];
    int                            num_cases;
    bit                            cases_loaded;

    logic [rec_w-1:0] exp_q [$];
    int               error_count;
    int               retired;

    rv_alu_core rv_alu_core_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .retire_valid   (retire_valid),
        .retire_illegal (retire_illegal),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // one case per line, '#' lines skipped
    task automatic load_cases();
        int                      fd;
        int                      n;
        int                      fields;
        string                   line;
        logic [31:0]             word;
        logic [rv_pkg::xlen-1:0] data;
        int                      rd;
        int                      ill;
        int                      burst;
        fd = $fopen(cases_file, "r");
        if (fd == 0)
        begin
            $display("could not open %s", cases_file);
            error_count++;
        end
        else
        begin
            while (!$feof(fd) && num_cases < max_cases)
            begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != 8'h23)
                begin
                    fields = $sscanf(line, "%h %d %h %d %d", word, rd, data, ill, burst);
                    if (fields == 5)
                    begin
                        case_instr[num_cases]   = word;
                        case_rd[num_cases]      = rd[rv_pkg::reg_addr_w-1:0];
                        case_data[num_cases]    = data;
                        case_illegal[num_cases] = (ill != 0);
                        case_burst[num_cases]   = (burst != 0);
                        num_cases++;
                    end
                    else if (fields > 0)
                    begin
                        $display("malformed line in cases file: %s", line);
                        error_count++;
                    end
                end
            end
            $fclose(fd);
        end
        if (num_cases == 0)
        begin
            $display("no cases loaded, nothing to run");
            error_count++;
        end
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the next one
    task automatic issue_case(input int idx);
        instr_valid = 1'b1;
        instr       = case_instr[idx];
        exp_q.push_back({case_illegal[idx], case_rd[idx], case_data[idx]});
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr       = '0;
    endtask

    task automatic check_retire();
        logic [rec_w-1:0]              exp;
        logic                          exp_illegal;
        logic [rv_pkg::reg_addr_w-1:0] exp_rd;
        logic [rv_pkg::xlen-1:0]       exp_data;
        if (exp_q.size() == 0)
        begin
            $display("%0t: retire of x%0d with no instruction outstanding", $time, retire_rd);
            error_count++;
        end
        else
        begin
            exp         = exp_q.pop_front();
            exp_illegal = exp[rec_w-1];
            exp_rd      = exp[rv_pkg::xlen +: rv_pkg::reg_addr_w];
            exp_data    = exp[rv_pkg::xlen-1:0];
            retired++;
            if (retire_illegal !== exp_illegal)
            begin
                $display("Mismatch at %0t: retire_illegal expected %0b got %0b",
                         $time, exp_illegal, retire_illegal);
                error_count++;
            end
            if (retire_rd !== exp_rd)
            begin
                $display("Mismatch at %0t: retire_rd expected %0d got %0d",
                         $time, exp_rd, retire_rd);
                error_count++;
            end
            // data of an illegal retire carries no meaning
            if (!exp_illegal && retire_data !== exp_data)
            begin
                $display("Mismatch at %0t: retire_data expected %08h got %08h",
                         $time, exp_data, retire_data);
                error_count++;
            end
        end
    endtask

    // closing summary, then end of run
    task automatic finish_run();
        int assert_fails;
        assert_fails = rv_alu_core_inst.rv_alu_core_checker_inst.fail_count;
        if (exp_q.size() != 0)
        begin
            $display("%0d expected retires never arrived", exp_q.size());
            error_count++;
        end
        $display("cases %0d, retired %0d, errors %0d, assertion failures %0d",
                 num_cases, retired, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk)
    begin
        if (retire_valid)
            check_retire();
    end

    // watchdog, 4 cycles per case plus margin
    initial
    begin
        wait (cases_loaded);
        repeat (num_cases * 4 + 50) @(posedge clk);
        $display("timeout after %0d cycles, retire stream incomplete", num_cases * 4 + 50);
        error_count++;
        finish_run();
    end

    initial
    begin
        int gap;
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        error_count  = 0;
        retired      = 0;
        num_cases    = 0;
        cases_loaded = 1'b0;
        void'($urandom(seed));
        load_cases();
        cases_loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        for (int i = 0; i < num_cases; i++)
        begin
            issue_case(i);
            // burst cases keep the forwarding paths busy
            gap = case_burst[i] ? 0 : int'($urandom % 3);
            repeat (gap)
            begin
                @(posedge clk);
                #1;
            end
        end
        // drain, then an idle window where nothing may retire
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (6) @(posedge clk);
        finish_run();
    end

endmodule

`default_nettype wire

// ==== project.f ====
common/rv_pkg.sv
design/regfile.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/rv_alu_core.sv
bench/rv_alu_core_checker.sv
bench/rv_alu_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the rv_alu_core testbench with Verilator and run it
# exit status follows the pass line in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module rv_alu_core_tb \
    -f project.f \
    -o rv_alu_core_sim \
    && ./obj_dir/rv_alu_core_sim +verilator+error+limit+1000 \
        | tee /dev/stderr \
        | grep -x "Result: PASSED" > /dev/null \
    && echo "simulation passed" \
    && exit 0 \
    || { echo "simulation failed"; exit 1; }

// ==== bench/alu_cases.txt ====
# columns: instr (hex)  rd (dec)  data (hex)  illegal (0/1)  burst (1 = next follows at once)
# data is not compared when illegal is 1
# register-register and immediate alu, lui
00500093  1 00000005 0 0
FFD00113  2 FFFFFFFD 0 0
800001B7  3 80000000 0 0
00208233  4 00000002 0 0
402082B3  5 00000008 0 0
00109333  6 000000A0 0 0
001123B3  7 00000001 0 0
00113433  8 00000000 0 0
0020C4B3  9 FFFFFFF8 0 0
0011D533 10 04000000 0 0
4011D5B3 11 FC000000 0 0
0020E633 12 FFFFFFFD 0 0
0020F6B3 13 00000005 0 0
FFF12713 14 00000001 0 0
FFF0B793 15 00000001 0 0
0F00C813 16 000000F5 0 0
1000E893 17 00000105 0 0
7FF17913 18 000007FD 0 0
01C09993 19 50000000 0 0
00415A13 20 0FFFFFFF 0 0
40415A93 21 FFFFFFFF 0 0
# forwarding at distance 1, 2, 3, then register file, then youngest writer
06400293  5 00000064 0 1
00128313  6 00000065 0 1
00228393  7 00000066 0 1
00628433  8 000000C9 0 1
407404B3  9 00000063 0 1
00028533 10 00000064 0 0
00100593 11 00000001 0 1
00200593 11 00000002 0 1
00058613 12 00000002 0 0
# x0 written, reads stay zero
00700013  0 00000007 0 1
00000693 13 00000000 0 0
00000733 14 00000000 0 0
# illegal encodings keep old register values
401097B3 15 00000000 1 1
0000080B 16 00000000 1 1
40109893 17 00000000 1 1
0210D913 18 00000000 1 1
00090A13 20 000007FD 0 1
00078993 19 00000001 0 1
00080A93 21 000000F5 0 0
